// File: Makefile
VERILATOR ?= verilator
TOP       ?= decode_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SIM_ARGS  ?= +verilator+error+limit+100

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --assert --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/mips_pkg.sv
package mips_pkg;

  // primary opcodes, instr[31:26]
  localparam logic [5:0] op_rtype = 6'b000000;
  localparam logic [5:0] op_lw    = 6'b100011;
  localparam logic [5:0] op_sw    = 6'b101011;
  localparam logic [5:0] op_beq   = 6'b000100;
  localparam logic [5:0] op_addi  = 6'b001000;
  localparam logic [5:0] op_j     = 6'b000010;
  localparam logic [5:0] op_jal   = 6'b000011;

  // funct field for r-type, instr[5:0]
  localparam logic [5:0] fn_add     = 6'b100000;
  localparam logic [5:0] fn_sub     = 6'b100010;
  localparam logic [5:0] fn_and     = 6'b100100;
  localparam logic [5:0] fn_or      = 6'b100101;
  localparam logic [5:0] fn_slt     = 6'b101010;
  localparam logic [5:0] fn_jr      = 6'b001000;
  localparam logic [5:0] fn_syscall = 6'b001100;

  // alu control seen by execute
  localparam logic [2:0] alu_and = 3'b000;
  localparam logic [2:0] alu_or  = 3'b001;
  localparam logic [2:0] alu_add = 3'b010;
  localparam logic [2:0] alu_sub = 3'b110;
  localparam logic [2:0] alu_slt = 3'b111;

  // fixed register numbers
  localparam logic [4:0] reg_ra = 5'd31; // jal link
  localparam logic [4:0] reg_v0 = 5'd2;  // syscall code
  localparam logic [4:0] reg_a0 = 5'd4;  // syscall argument

  // decoded controls, all zero is a bubble
  typedef struct packed {
    logic       reg_write;
    logic       mem_to_reg;
    logic       mem_write;
    logic       alu_src;    // immediate into alu b
    logic       reg_dst;    // rd instead of rt
    logic [2:0] alu_ctrl;
    logic       branch;
    logic       jump;
    logic       jump_reg;
    logic       jal;
    logic       syscall;
  } ctrl_t;

  // if/id payload
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc_plus_4;
  } if_id_t;

  // id/ex payload
  typedef struct packed {
    ctrl_t       ctrl;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [31:0] sign_imm;
    logic [31:0] syscall_instr; // whole word for the syscall unit
    logic [31:0] v0;
    logic [31:0] a0;
  } id_ex_t;

endpackage

// File: decode/control.sv
`timescale 1ns/1ns

module control (
  input  logic [31:0]         instr,
  output mips_pkg::ctrl_t     ctrl
);

  logic [5:0] opcode;
  logic [5:0] funct;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];

  always_comb begin
    ctrl = '0; // unknown encodings fall through as a bubble
    case (opcode)
      mips_pkg::op_rtype: begin
        case (funct)
          mips_pkg::fn_add, mips_pkg::fn_sub, mips_pkg::fn_and,
          mips_pkg::fn_or, mips_pkg::fn_slt: begin
            ctrl.reg_write = 1'b1;
            ctrl.reg_dst   = 1'b1; // result goes to rd
            case (funct)
              mips_pkg::fn_add: ctrl.alu_ctrl = mips_pkg::alu_add;
              mips_pkg::fn_sub: ctrl.alu_ctrl = mips_pkg::alu_sub;
              mips_pkg::fn_and: ctrl.alu_ctrl = mips_pkg::alu_and;
              mips_pkg::fn_or:  ctrl.alu_ctrl = mips_pkg::alu_or;
              default:          ctrl.alu_ctrl = mips_pkg::alu_slt;
            endcase
          end
          mips_pkg::fn_jr:      ctrl.jump_reg = 1'b1; // no register result
          mips_pkg::fn_syscall: ctrl.syscall  = 1'b1;
          default:              ctrl = '0; // sll 0 and friends, treated as nop
        endcase
      end
      mips_pkg::op_lw: begin
        ctrl.reg_write  = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.alu_src    = 1'b1;
        ctrl.alu_ctrl   = mips_pkg::alu_add; // base + offset
      end
      mips_pkg::op_sw: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_ctrl  = mips_pkg::alu_add;
      end
      mips_pkg::op_beq: begin
        ctrl.branch   = 1'b1; // resolved here in decode
        ctrl.alu_ctrl = mips_pkg::alu_sub;
      end
      mips_pkg::op_addi: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_ctrl  = mips_pkg::alu_add;
      end
      mips_pkg::op_j: ctrl.jump = 1'b1;
      mips_pkg::op_jal: begin
        ctrl.jump = 1'b1;
        ctrl.jal  = 1'b1; // ra written from decode, not writeback
      end
      default: ctrl = '0;
    endcase
  end

endmodule

// File: decode/decode.sv
`timescale 1ns/1ns

module decode (
  input  logic             clk,
  input  logic             reset,
  input  logic             stall,
  input  mips_pkg::if_id_t if_id,
  input  logic             forward_a,    // rs from memory stage
  input  logic             forward_b,    // rt from memory stage
  input  logic [31:0]      mem_alu_out,
  input  logic             wb_reg_write,
  input  logic [4:0]       wb_reg,
  input  logic [31:0]      wb_data,
  output mips_pkg::id_ex_t id_ex,
  output logic             pcsrc,
  output logic [31:0]      branch_target,
  output logic [31:0]      jump_target,
  output logic [31:0]      jr_target,
  output logic             redirect
);

  mips_pkg::ctrl_t ctrl;
  logic [31:0] instr;
  logic [31:0] pc_plus_4;
  logic [31:0] rd1;
  logic [31:0] rd2;
  logic [31:0] v0;
  logic [31:0] a0;
  logic [31:0] sign_imm;
  logic [31:0] cmp_a;     // rs after forwarding
  logic [31:0] cmp_b;     // rt after forwarding
  logic        jal_write;
  logic [31:0] jal_data;

  assign instr     = if_id.instr;
  assign pc_plus_4 = if_id.pc_plus_4;

  control u_control (
    .instr (instr),
    .ctrl  (ctrl)
  );

  // link write held off while stalled so it lands once
  assign jal_write = ctrl.jal & ~stall;
  assign jal_data  = pc_plus_4 + 32'd4;

  registers u_registers (
    .clk          (clk),
    .reset        (reset),
    .rs           (instr[25:21]),
    .rt           (instr[20:16]),
    .rd1          (rd1),
    .rd2          (rd2),
    .wb_reg_write (wb_reg_write),
    .wb_reg       (wb_reg),
    .wb_data      (wb_data),
    .jal_write    (jal_write),
    .jal_data     (jal_data),
    .v0           (v0),
    .a0           (a0)
  );

  assign sign_imm = {{16{instr[15]}}, instr[15:0]};

  assign branch_target = pc_plus_4 + {sign_imm[29:0], 2'b00}; // word offset
  assign jump_target   = {pc_plus_4[31:28], instr[25:0], 2'b00};

  // early branch compare, operands may come from memory stage
  assign cmp_a = forward_a ? mem_alu_out : rd1;
  assign cmp_b = forward_b ? mem_alu_out : rd2;

  assign jr_target = cmp_a;
  assign pcsrc     = ctrl.branch & (cmp_a == cmp_b);
  assign redirect  = pcsrc | ctrl.jump | ctrl.jump_reg; // flush the slot behind

  always_comb begin
    id_ex               = '0;
    id_ex.ctrl          = ctrl;
    id_ex.rd1           = rd1;
    id_ex.rd2           = rd2;
    id_ex.rs            = instr[25:21];
    id_ex.rt            = instr[20:16];
    id_ex.rd            = instr[15:11];
    id_ex.sign_imm      = sign_imm;
    id_ex.syscall_instr = instr;
    id_ex.v0            = v0;
    id_ex.a0            = a0;
  end

endmodule

// File: decode/registers.sv
`timescale 1ns/1ns

module registers (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  rs,
  input  logic [4:0]  rt,
  output logic [31:0] rd1,
  output logic [31:0] rd2,
  input  logic        wb_reg_write,
  input  logic [4:0]  wb_reg,
  input  logic [31:0] wb_data,
  input  logic        jal_write,
  input  logic [31:0] jal_data,
  output logic [31:0] v0,
  output logic [31:0] a0
);

  logic [31:0] rf [0:31]; // entry 0 never written
  logic        we;
  logic [4:0]  wa;
  logic [31:0] wd;

  // single write port, jal wins over writeback
  assign we = jal_write | (wb_reg_write & (wb_reg != 5'd0));
  assign wa = jal_write ? mips_pkg::reg_ra : wb_reg;
  assign wd = jal_write ? jal_data : wb_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) rf[i] <= '0;
    end else if (we) begin
      rf[wa] <= wd;
    end
  end

  // read with bypass of the write landing this edge
  function automatic logic [31:0] read_port(input logic [4:0] addr);
    logic [31:0] val;
    if (addr == 5'd0) val = '0;          // $zero
    else if (we && wa == addr) val = wd; // same-cycle write
    else val = rf[addr];
    return val;
  endfunction

  always_comb begin
    rd1 = read_port(rs);
    rd2 = read_port(rt);
    v0  = read_port(mips_pkg::reg_v0); // syscall taps
    a0  = read_port(mips_pkg::reg_a0);
  end

endmodule

// File: verification/decode_checker.sv
`timescale 1ns/1ns

module decode_checker (
  input logic             clk,
  input logic             reset,
  input logic [31:0]      instr,
  input logic [31:0]      pc_plus_4,
  input logic             stall,
  input logic             forward_a,
  input logic             forward_b,
  input logic [31:0]      mem_alu_out,
  input logic             wb_reg_write,
  input logic [4:0]       wb_reg,
  input logic [31:0]      wb_data,
  input mips_pkg::id_ex_t id_ex,
  input logic             pcsrc,
  input logic             jump,
  input logic             jump_reg,
  input logic [31:0]      branch_target,
  input logic [31:0]      jump_target,
  input logic [31:0]      jr_target,
  input logic [4:0]       stall_rs,
  input logic [4:0]       stall_rt
);

  int               fails = 0;   // first failure is kept below
  string            err_name;
  logic [255:0]     err_exp;
  logic [255:0]     err_act;
  time              err_time;
  logic [31:0]      m_instr;     // model of the if/id register
  logic [31:0]      m_pc;
  logic [31:0]      shadow [0:31];
  mips_pkg::ctrl_t  c;
  mips_pkg::id_ex_t exp_d;
  mips_pkg::id_ex_t exp_q;       // model of the id/ex register
  logic             link;
  logic [31:0]      jal_val;
  logic [31:0]      ca;
  logic [31:0]      cb;
  logic [31:0]      simm;
  logic             exp_pcsrc;
  logic             redirect;

  // control table from the opcode and funct encodings
  function automatic mips_pkg::ctrl_t exp_ctrl(input logic [31:0] w);
    mips_pkg::ctrl_t x;
    x = '0;
    case (w[31:26])
      mips_pkg::op_rtype: begin
        case (w[5:0])
          mips_pkg::fn_add: {x.reg_write, x.reg_dst, x.alu_ctrl} = {2'b11, mips_pkg::alu_add};
          mips_pkg::fn_sub: {x.reg_write, x.reg_dst, x.alu_ctrl} = {2'b11, mips_pkg::alu_sub};
          mips_pkg::fn_and: {x.reg_write, x.reg_dst, x.alu_ctrl} = {2'b11, mips_pkg::alu_and};
          mips_pkg::fn_or:  {x.reg_write, x.reg_dst, x.alu_ctrl} = {2'b11, mips_pkg::alu_or};
          mips_pkg::fn_slt: {x.reg_write, x.reg_dst, x.alu_ctrl} = {2'b11, mips_pkg::alu_slt};
          mips_pkg::fn_jr:      x.jump_reg = 1'b1;
          mips_pkg::fn_syscall: x.syscall  = 1'b1;
          default: x = '0; // nop
        endcase
      end
      mips_pkg::op_lw:
        {x.reg_write, x.mem_to_reg, x.alu_src, x.alu_ctrl} = {3'b111, mips_pkg::alu_add};
      mips_pkg::op_sw:   {x.mem_write, x.alu_src, x.alu_ctrl} = {2'b11, mips_pkg::alu_add};
      mips_pkg::op_beq:  {x.branch, x.alu_ctrl} = {1'b1, mips_pkg::alu_sub};
      mips_pkg::op_addi: {x.reg_write, x.alu_src, x.alu_ctrl} = {2'b11, mips_pkg::alu_add};
      mips_pkg::op_j:    x.jump = 1'b1;
      mips_pkg::op_jal:  {x.jump, x.jal} = 2'b11;
      default: x = '0;
    endcase
    return x;
  endfunction

  // register read as seen this cycle with jal ahead of wb
  function automatic logic [31:0] val(input logic [4:0] r);
    if (r == 5'd0) return '0;
    if (link && r == mips_pkg::reg_ra) return jal_val;
    if (!link && wb_reg_write && wb_reg == r) return wb_data;
    return shadow[r];
  endfunction

  function automatic void note(input string name, input logic [255:0] e, input logic [255:0] a);
    if (fails == 0) begin
      err_name = name;
      err_exp  = e;
      err_act  = a;
      err_time = $time;
    end
    fails++;
  endfunction

  assign c       = exp_ctrl(m_instr);
  assign link    = c.jal & ~stall; // no link write while held
  assign jal_val = m_pc + 32'd4;

  always_comb begin
    ca        = forward_a ? mem_alu_out : val(m_instr[25:21]);
    cb        = forward_b ? mem_alu_out : val(m_instr[20:16]);
    exp_pcsrc = c.branch & (ca == cb);
    redirect  = exp_pcsrc | c.jump | c.jump_reg;
    simm      = {{16{m_instr[15]}}, m_instr[15:0]};
    exp_d               = '0;
    exp_d.ctrl          = c;
    exp_d.rd1           = val(m_instr[25:21]);
    exp_d.rd2           = val(m_instr[20:16]);
    exp_d.rs            = m_instr[25:21];
    exp_d.rt            = m_instr[20:16];
    exp_d.rd            = m_instr[15:11];
    exp_d.sign_imm      = simm;
    exp_d.syscall_instr = m_instr;
    exp_d.v0            = val(5'd2);
    exp_d.a0            = val(5'd4);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      m_instr <= '0;
      m_pc    <= '0;
      exp_q   <= '0;
      for (int i = 0; i < 32; i++) shadow[i] <= '0;
    end else begin
      exp_q <= stall ? '0 : exp_d; // bubble per stalled cycle
      if (!stall) begin
        m_instr <= redirect ? '0 : instr; // slot behind a redirect flushed
        m_pc    <= redirect ? '0 : pc_plus_4;
      end
      if (link) shadow[31] <= jal_val;
      else if (wb_reg_write && wb_reg != 5'd0) shadow[wb_reg] <= wb_data;
    end
  end

  a_id_ex: assert property (@(posedge clk) disable iff (reset) id_ex == exp_q)
    else begin
      note("id_ex", 256'($sampled(exp_q)), 256'($sampled(id_ex)));
      $error("id_ex differs from model");
    end

  a_pcsrc: assert property (@(posedge clk) disable iff (reset) pcsrc == exp_pcsrc)
    else begin
      note("pcsrc", 256'($sampled(exp_pcsrc)), 256'($sampled(pcsrc)));
      $error("pcsrc differs from model");
    end

  a_jump: assert property (@(posedge clk) disable iff (reset)
                           {jump, jump_reg} == {c.jump, c.jump_reg})
    else begin
      note("jump/jump_reg", 256'($sampled({c.jump, c.jump_reg})),
           256'($sampled({jump, jump_reg})));
      $error("jump or jump_reg differs from model");
    end

  a_targets: assert property (@(posedge clk) disable iff (reset)
    {branch_target, jump_target, jr_target} ==
    {m_pc + {simm[29:0], 2'b00}, m_pc[31:28], m_instr[25:0], 2'b00, ca})
    else begin
      note("branch_target/jump_target/jr_target",
           256'($sampled({m_pc + {simm[29:0], 2'b00}, m_pc[31:28], m_instr[25:0], 2'b00, ca})),
           256'($sampled({branch_target, jump_target, jr_target})));
      $error("a target output differs from model");
    end

  // register numbers handed to the hazard unit
  a_stall_regs: assert property (@(posedge clk) disable iff (reset)
                                 {stall_rs, stall_rt} == {m_instr[25:21], m_instr[20:16]})
    else begin
      note("stall_rs/stall_rt", 256'($sampled({m_instr[25:21], m_instr[20:16]})),
           256'($sampled({stall_rs, stall_rt})));
      $error("stall_rs or stall_rt differs from model");
    end

endmodule

bind decode_top decode_checker u_checker (.*);

// File: verification/decode_tb.sv
`timescale 1ns/1ns

module decode_tb;

  localparam int max_cycles = 400; // stimulus needs about 240

  logic             clk = 1'b0;
  logic             reset;
  logic [31:0]      instr;
  logic [31:0]      pc_plus_4;
  logic             stall;
  logic             forward_a;
  logic             forward_b;
  logic [31:0]      mem_alu_out;
  logic             wb_reg_write;
  logic [4:0]       wb_reg;
  logic [31:0]      wb_data;
  mips_pkg::id_ex_t id_ex;
  logic             pcsrc;
  logic             jump;
  logic             jump_reg;
  logic [31:0]      branch_target;
  logic [31:0]      jump_target;
  logic [31:0]      jr_target;
  logic [4:0]       stall_rs;
  logic [4:0]       stall_rt;
  integer           seed = 32'h70c0;
  int               cycles = 0;

  decode_top i_dut (.*);

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("Test FAILED");
      $fatal(1, "timeout");
    end
  end

  // assertion results from the posedge are settled by the falling edge
  always @(negedge clk) begin
    if (i_dut.u_checker.fails != 0) begin
      $display("FAIL time=%0t %s expected %h actual %h", i_dut.u_checker.err_time,
               i_dut.u_checker.err_name, i_dut.u_checker.err_exp, i_dut.u_checker.err_act);
      $display("Test FAILED");
      $fatal(1, "assertion failure");
    end
  end

  // kind 0..12 picks an instruction class, 13 and up give a nop
  function automatic logic [31:0] make_instr(input logic [31:0] k, input logic [31:0] r,
                                            input logic [4:0] rs, input logic [4:0] rt);
    logic [31:0] w;
    w = r;
    w[25:21] = rs;
    w[20:16] = rt;
    case (k)
      0:  {w[31:26], w[5:0]} = {mips_pkg::op_rtype, mips_pkg::fn_add};
      1:  {w[31:26], w[5:0]} = {mips_pkg::op_rtype, mips_pkg::fn_sub};
      2:  {w[31:26], w[5:0]} = {mips_pkg::op_rtype, mips_pkg::fn_and};
      3:  {w[31:26], w[5:0]} = {mips_pkg::op_rtype, mips_pkg::fn_or};
      4:  {w[31:26], w[5:0]} = {mips_pkg::op_rtype, mips_pkg::fn_slt};
      5:  {w[31:26], w[5:0]} = {mips_pkg::op_rtype, mips_pkg::fn_jr};
      6:  {w[31:26], w[5:0]} = {mips_pkg::op_rtype, mips_pkg::fn_syscall};
      7:  w[31:26] = mips_pkg::op_lw;
      8:  w[31:26] = mips_pkg::op_sw;
      9:  w[31:26] = mips_pkg::op_addi;
      10: w[31:26] = mips_pkg::op_beq;
      11: w[31:26] = mips_pkg::op_j;
      12: w[31:26] = mips_pkg::op_jal;
      default: w = '0;
    endcase
    return w;
  endfunction

  initial begin
    logic [31:0] r;
    logic [4:0]  rs;
    logic [4:0]  rt;
    reset = 1'b1;
    instr = '0;
    pc_plus_4 = 32'h0040_0000;
    stall = 1'b0;
    forward_a = 1'b0;
    forward_b = 1'b0;
    mem_alu_out = '0;
    wb_reg_write = 1'b0;
    wb_reg = '0;
    wb_data = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    // known register contents through the wb port
    for (int i = 1; i < 32; i++) begin
      wb_reg_write = 1'b1;
      wb_reg = i[4:0];
      wb_data = $random(seed);
      @(negedge clk);
    end
    for (int n = 0; n < 200; n++) begin
      r  = $random(seed);
      rs = r[7] ? 5'd31 : {2'b00, r[10:8]};
      rt = r[11] ? rs : {2'b00, r[14:12]}; // equal operands often, so beq takes
      instr = make_instr(r % 15, $random(seed), rs, rt);
      r = $random(seed);
      stall = (r[2:0] == 3'd0);
      forward_a = (r[4:3] == 2'd0);
      forward_b = (r[6:5] == 2'd0);
      mem_alu_out = $random(seed);
      wb_reg_write = r[7] & r[8];
      wb_reg = r[13:9];
      wb_data = $random(seed);
      if (!stall) pc_plus_4 = pc_plus_4 + 32'd4;
      @(negedge clk);
    end
    instr = '0;
    stall = 1'b0;
    wb_reg_write = 1'b0;
    repeat (3) @(negedge clk);
    if (i_dut.u_checker.fails == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
common/mips_pkg.sv
verilog/pipe_reg.sv
decode/control.sv
decode/registers.sv
decode/decode.sv
verilog/decode_top.sv
verification/decode_checker.sv
verification/decode_tb.sv

// File: verilog/decode_top.sv
`timescale 1ns/1ns

module decode_top (
  input  logic             clk,
  input  logic             reset,
  input  logic [31:0]      instr,
  input  logic [31:0]      pc_plus_4,
  input  logic             stall,
  input  logic             forward_a,
  input  logic             forward_b,
  input  logic [31:0]      mem_alu_out,
  input  logic             wb_reg_write,
  input  logic [4:0]       wb_reg,
  input  logic [31:0]      wb_data,
  output mips_pkg::id_ex_t id_ex,
  output logic             pcsrc,
  output logic             jump,
  output logic             jump_reg,
  output logic [31:0]      branch_target,
  output logic [31:0]      jump_target,
  output logic [31:0]      jr_target,
  output logic [4:0]       stall_rs,
  output logic [4:0]       stall_rt
);

  mips_pkg::if_id_t if_id_d;
  mips_pkg::if_id_t if_id_q;
  mips_pkg::id_ex_t id_ex_d;  // decoded, before the id/ex register
  logic             redirect;

  assign if_id_d.instr     = instr;
  assign if_id_d.pc_plus_4 = pc_plus_4;

  pipe_reg #(.payload_t(mips_pkg::if_id_t)) u_if_id (
    .clk    (clk),
    .reset  (reset),
    .enable (~stall),
    .clear  (redirect & ~stall), // a stall keeps the held instruction
    .d      (if_id_d),
    .q      (if_id_q)
  );

  decode u_decode (
    .clk           (clk),
    .reset         (reset),
    .stall         (stall),
    .if_id         (if_id_q),
    .forward_a     (forward_a),
    .forward_b     (forward_b),
    .mem_alu_out   (mem_alu_out),
    .wb_reg_write  (wb_reg_write),
    .wb_reg        (wb_reg),
    .wb_data       (wb_data),
    .id_ex         (id_ex_d),
    .pcsrc         (pcsrc),
    .branch_target (branch_target),
    .jump_target   (jump_target),
    .jr_target     (jr_target),
    .redirect      (redirect)
  );

  pipe_reg #(.payload_t(mips_pkg::id_ex_t)) u_id_ex (
    .clk    (clk),
    .reset  (reset),
    .enable (1'b1),
    .clear  (stall), // bubble per stalled cycle
    .d      (id_ex_d),
    .q      (id_ex)
  );

  assign jump     = id_ex_d.ctrl.jump;
  assign jump_reg = id_ex_d.ctrl.jump_reg;
  assign stall_rs = if_id_q.instr[25:21]; // hazard unit compares these
  assign stall_rt = if_id_q.instr[20:16];

endmodule

// File: verilog/pipe_reg.sv
`timescale 1ns/1ns

module pipe_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     enable,  // load d
  input  logic     clear,   // load a bubble
  input  payload_t d,
  output payload_t q
);

  // reset, then clear, then enable, else hold
  always_ff @(posedge clk) begin
    if (reset) begin
      q <= '0;
    end else if (clear) begin
      q <= '0; // zero word is a nop
    end else if (enable) begin
      q <= d;
    end
  end

endmodule
